// ==== Makefile ====
# Verilator build and run for the quad-SPI PSRAM controller.
TOP := tb_qspi_psram_ctrl

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/10ps -f project.f \
		--top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q '^\*\* PASS \*\*$$' sim.log

clean:
	rm -rf obj_dir sim.log

// ==== project.f ====
rtl/qspi_pkg.sv
rtl/qspi_req_decode.sv
rtl/qspi_sequencer.sv
rtl/qspi_result.sv
rtl/qspi_psram_ctrl.sv
tests/psram_model.sv
tests/tb_qspi_psram_ctrl.sv

// ==== rtl/qspi_pkg.sv ====
// Shared definitions for the quad-SPI PSRAM controller.
// Holds the transfer descriptor, the device command codes and the phase lengths.

package qspi_pkg;

  // One transfer as seen by the serial sequencer.
  // Write data is left-aligned so the first byte on the wire sits in [31:24].
  typedef struct packed {
    logic        is_write;
    logic [1:0]  chip;
    logic [7:0]  cmd;
    logic [23:0] addr;
    logic [31:0] wdata;
    logic [5:0]  data_bits;
  } xfer_desc_t;

  // Quad commands, used when the device runs in QPI style mode.
  localparam logic [7:0] cmd_quad_write = 8'h38;
  localparam logic [7:0] cmd_quad_read  = 8'hEB;

  // Single-line commands for plain SPI operation.
  localparam logic [7:0] cmd_write = 8'h02;
  localparam logic [7:0] cmd_read  = 8'h03;

  // Phase lengths, counted in bits on the wire.
  // The command always goes out one bit per sclk phase.
  localparam logic [5:0] cmd_bits  = 6'd8;
  localparam logic [5:0] addr_bits = 6'd24;

  // Full word transfer, used for every read.
  localparam logic [5:0] word_bits = 6'd32;

  // Partial write lengths.
  localparam logic [5:0] byte_bits = 6'd8;
  localparam logic [5:0] half_bits = 6'd16;

  // Wait phases between address and read data in quad mode.
  // The lines are released while these clocks run.
  localparam logic [5:0] dummy_clocks = 6'd6;

endpackage

// ==== rtl/qspi_psram_ctrl.sv ====
// Memory-mapped quad-SPI PSRAM controller, top level.
// Serves word reads and byte, halfword and word writes for up to four chips,
// with addr[22:21] selecting the chip on the shared serial bus.

`timescale 1ns/10ps

module qspi_psram_ctrl import qspi_pkg::*; #(
  parameter bit quad_mode        = 1'b1,
  parameter bit psram_addressing = 1'b1,
  parameter bit cen_active_high  = 1'b0
) (
  input  logic        clk,
  input  logic        resetn,
  input  logic [22:0] addr,
  input  logic [31:0] wdata,
  input  logic [3:0]  wstrb,
  input  logic        valid,
  output logic [31:0] rdata,
  output logic        ready,
  output logic        cen,
  output logic        sclk,
  output logic [1:0]  cs,
  inout  wire         sio0,
  inout  wire         sio1,
  inout  wire         sio2,
  inout  wire         sio3
);

  xfer_desc_t  desc;
  logic        start;
  logic        busy;
  logic        done;
  logic [31:0] shift_data;
  logic [3:0]  sio_out;
  logic [3:0]  sio_oe;
  logic [3:0]  sio_in;

  // Each line is released on its own enable bit.
  assign sio0   = sio_oe[0] ? sio_out[0] : 1'bz;
  assign sio1   = sio_oe[1] ? sio_out[1] : 1'bz;
  assign sio2   = sio_oe[2] ? sio_out[2] : 1'bz;
  assign sio3   = sio_oe[3] ? sio_out[3] : 1'bz;
  assign sio_in = {sio3, sio2, sio1, sio0};

  qspi_req_decode #(
    .quad_mode        (quad_mode),
    .psram_addressing (psram_addressing)
  ) u_decode (
    .addr  (addr),
    .wdata (wdata),
    .wstrb (wstrb),
    .desc  (desc)
  );

  qspi_sequencer #(
    .quad_mode       (quad_mode),
    .cen_active_high (cen_active_high)
  ) u_sequencer (
    .clk        (clk),
    .resetn     (resetn),
    .start      (start),
    .desc       (desc),
    .busy       (busy),
    .done       (done),
    .shift_data (shift_data),
    .cen        (cen),
    .sclk       (sclk),
    .cs         (cs),
    .sio_out    (sio_out),
    .sio_oe     (sio_oe),
    .sio_in     (sio_in)
  );

  qspi_result #(
    .psram_addressing (psram_addressing)
  ) u_result (
    .clk        (clk),
    .resetn     (resetn),
    .valid      (valid),
    .is_write   (desc.is_write),
    .busy       (busy),
    .done       (done),
    .shift_data (shift_data),
    .start      (start),
    .ready      (ready),
    .rdata      (rdata)
  );

endmodule

// ==== rtl/qspi_req_decode.sv ====
// Request decode for the quad-SPI PSRAM controller.
// Turns a held bus request into a transfer descriptor: command, device
// address, left-aligned write data and the length of the data phase.

`timescale 1ns/10ps

module qspi_req_decode import qspi_pkg::*; #(
  parameter bit quad_mode        = 1'b1,
  parameter bit psram_addressing = 1'b1
) (
  input  logic [22:0] addr,
  input  logic [31:0] wdata,
  input  logic [3:0]  wstrb,
  output xfer_desc_t  desc
);

  logic        is_write;
  logic [1:0]  byte_offset;
  logic [31:0] wr_aligned;
  logic [5:0]  wr_bits;
  logic [23:0] dev_addr;

  assign is_write = |wstrb;

  // Lane 3 is the lowest device byte, so lane 0 maps to offset 3.
  always_comb begin
    wr_aligned = wdata;
    case (wstrb)
      4'b0001: begin
        byte_offset       = 2'd3;
        wr_aligned[31:24] = wdata[7:0];
        wr_bits           = byte_bits;
      end
      4'b0010: begin
        byte_offset       = 2'd2;
        wr_aligned[31:24] = wdata[15:8];
        wr_bits           = byte_bits;
      end
      4'b0100: begin
        byte_offset       = 2'd1;
        wr_aligned[31:24] = wdata[23:16];
        wr_bits           = byte_bits;
      end
      4'b1000: begin
        byte_offset = 2'd0;
        wr_bits     = byte_bits;
      end
      4'b0011: begin
        byte_offset       = 2'd2;
        wr_aligned[31:16] = wdata[15:0];
        wr_bits           = half_bits;
      end
      4'b1100: begin
        byte_offset = 2'd0;
        wr_bits     = half_bits;
      end
      // Reads and full words both start at the word boundary.
      default: begin
        byte_offset = 2'd0;
        wr_bits     = word_bits;
      end
    endcase
  end

  // PSRAM keeps the top address bit clear, flash uses the full 24 bits.
  assign dev_addr = psram_addressing ? {1'b0, addr[20:0], byte_offset}
                                     : {addr[21:0], byte_offset};

  always_comb begin
    desc.is_write  = is_write;
    desc.chip      = addr[22:21];
    if (quad_mode) begin
      desc.cmd = is_write ? cmd_quad_write : cmd_quad_read;
    end else begin
      desc.cmd = is_write ? cmd_write : cmd_read;
    end
    desc.addr      = dev_addr;
    desc.wdata     = wr_aligned;
    desc.data_bits = wr_bits;
  end

  // The master may only issue strobe patterns the device path can encode.
  always_comb begin
    assert (wstrb inside {4'b0000, 4'b0001, 4'b0010, 4'b0100, 4'b1000,
                          4'b0011, 4'b1100, 4'b1111})
      else $error("unsupported write strobe pattern %b", wstrb);
  end

endmodule

// ==== rtl/qspi_result.sv ====
// Result stage for the quad-SPI PSRAM controller.
// Tracks the valid/ready handshake, issues the start pulse and
// captures the read word once the sequencer is done.

`timescale 1ns/10ps

module qspi_result #(
  parameter bit psram_addressing = 1'b1
) (
  input  logic        clk,
  input  logic        resetn,
  input  logic        valid,
  input  logic        is_write,
  input  logic        busy,
  input  logic        done,
  input  logic [31:0] shift_data,
  output logic        start,
  output logic        ready,
  output logic [31:0] rdata
);

  // A new request waits until the previous ready has cleared.
  assign start = valid && !ready && !busy;

  // Ready is held until the master lets go of valid.
  always_ff @(posedge clk) begin
    if (!resetn) begin
      ready <= 1'b0;
    end else if (done) begin
      ready <= 1'b1;
    end else if (!valid) begin
      ready <= 1'b0;
    end
  end

  // Flash returns bytes in wire order, so swap them into a little endian word.
  always_ff @(posedge clk) begin
    if (done && !is_write) begin
      rdata <= psram_addressing ? shift_data
                                : {shift_data[7:0], shift_data[15:8],
                                   shift_data[23:16], shift_data[31:24]};
    end
  end

  assert property (@(posedge clk) disable iff (!resetn)
    $rose(ready) |-> $past(done));

endmodule

// ==== rtl/qspi_sequencer.sv ====
// Serial sequencer for the quad-SPI PSRAM controller.
// Runs select, command, address, wait and data phases over the shared bus,
// one or four bits per sclk phase, in both directions.

`timescale 1ns/10ps

module qspi_sequencer import qspi_pkg::*; #(
  parameter bit quad_mode       = 1'b1,
  parameter bit cen_active_high = 1'b0
) (
  input  logic        clk,
  input  logic        resetn,
  input  logic        start,
  input  xfer_desc_t  desc,
  output logic        busy,
  output logic        done,
  output logic [31:0] shift_data,
  output logic        cen,
  output logic        sclk,
  output logic [1:0]  cs,
  output logic [3:0]  sio_out,
  output logic [3:0]  sio_oe,
  input  logic [3:0]  sio_in
);

  // Each state names the phase that is loaded next.
  // The shift itself runs while bits_left is nonzero.
  typedef enum logic [2:0] {
    st_idle,
    st_select,
    st_cmd,
    st_addr,
    st_wait,
    st_data,
    st_finish
  } state_t;

  state_t      state;
  xfer_desc_t  req;
  logic [31:0] shift_buf;
  logic [5:0]  bits_left;
  logic        is_quad;
  logic        selected;
  logic        shifting;

  // Leading bits of a word as they go onto the lines.
  function automatic logic [3:0] lead_bits(input logic [31:0] value, input logic quad);
    lead_bits = quad ? value[31:28] : {3'b000, value[31]};
  endfunction

  assign shifting   = (bits_left != 6'd0);
  assign busy       = (state != st_idle);
  assign done       = (state == st_finish) && !shifting;
  assign shift_data = shift_buf;
  assign cen        = cen_active_high ? selected : ~selected;

  // Request is captured once so the bus side may change freely afterwards.
  always_ff @(posedge clk) begin
    if (start && state == st_idle) begin
      req <= desc;
    end
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      state     <= st_idle;
      bits_left <= 6'd0;
      is_quad   <= 1'b0;
      selected  <= 1'b0;
      sclk      <= 1'b0;
      cs        <= 2'b00;
      sio_oe    <= 4'b1111;
      sio_out   <= 4'b0000;
      shift_buf <= 32'h0;
    end else if (shifting) begin
      if (!sclk) begin
        // sclk rises here, so sample what the device put out.
        sclk      <= 1'b1;
        shift_buf <= is_quad ? {shift_buf[27:0], sio_in} : {shift_buf[30:0], sio_in[1]};
      end else begin
        sclk      <= 1'b0;
        bits_left <= bits_left - (is_quad ? 6'd4 : 6'd1);
        sio_out   <= lead_bits(shift_buf, is_quad);
      end
    end else begin
      case (state)
        st_idle: begin
          if (start) begin
            state <= st_select;
          end
        end
        st_select: begin
          cs       <= req.chip;
          selected <= 1'b1;
          sio_oe   <= 4'b0001;
          state    <= st_cmd;
        end
        st_cmd: begin
          shift_buf <= {req.cmd, 24'h0};
          sio_out   <= {3'b000, req.cmd[7]};
          bits_left <= cmd_bits;
          is_quad   <= 1'b0;
          state     <= st_addr;
        end
        st_addr: begin
          shift_buf <= {req.addr, 8'h00};
          sio_out   <= lead_bits({req.addr, 8'h00}, quad_mode);
          sio_oe    <= 4'b1111;
          bits_left <= addr_bits;
          is_quad   <= quad_mode;
          // Single-line reads and all writes go straight to data.
          state     <= (quad_mode && !req.is_write) ? st_wait : st_data;
        end
        st_wait: begin
          sio_oe    <= 4'b0000;
          bits_left <= dummy_clocks;
          is_quad   <= 1'b0;
          state     <= st_data;
        end
        st_data: begin
          is_quad <= quad_mode;
          if (req.is_write) begin
            shift_buf <= req.wdata;
            sio_out   <= lead_bits(req.wdata, quad_mode);
            sio_oe    <= 4'b1111;
            bits_left <= req.data_bits;
          end else begin
            sio_oe    <= 4'b0000;
            bits_left <= word_bits;
          end
          state <= st_finish;
        end
        st_finish: begin
          selected <= 1'b0;
          state    <= st_idle;
        end
        default: state <= st_idle;
      endcase
    end
  end

  // The device drives every line while read data is shifted in.
  assert property (@(posedge clk) disable iff (!resetn)
    (state == st_finish && shifting && !req.is_write) |-> (sio_oe == 4'b0000));

  // No clock edge may reach a device between transfers.
  assert property (@(posedge clk) disable iff (!resetn)
    (state == st_idle) |-> !sclk);

endmodule

// ==== tests/psram_model.sv ====
// Behavioral quad PSRAM for the controller testbench.
// Four chips share one bus, each with its own sparse byte store.
// Answers quad read EB and quad write 38, most significant nibble first.

`timescale 1ns/10ps

module psram_model (
  input  logic       cen,
  input  logic       sclk,
  input  logic [1:0] cs,
  inout  wire        sio0,
  inout  wire        sio1,
  inout  wire        sio2,
  inout  wire        sio3
);

  localparam logic [7:0] op_quad_read  = 8'hEB;
  localparam logic [7:0] op_quad_write = 8'h38;

  // Chip number sits above the device address, so the chips never share bytes.
  logic [7:0]  store [logic [25:0]];
  int          edge_count;
  logic [1:0]  chip;
  logic [7:0]  cmd;
  logic [23:0] dev_addr;
  logic [3:0]  high_nibble;
  logic [3:0]  drive_value;
  logic        drive_en;
  logic [3:0]  lines;

  assign lines = {sio3, sio2, sio1, sio0};
  assign sio0  = drive_en ? drive_value[0] : 1'bz;
  assign sio1  = drive_en ? drive_value[1] : 1'bz;
  assign sio2  = drive_en ? drive_value[2] : 1'bz;
  assign sio3  = drive_en ? drive_value[3] : 1'bz;

  function automatic logic [7:0] load_byte(input logic [1:0] c, input logic [23:0] a);
    if (store.exists({c, a})) begin
      return store[{c, a}];
    end
    return 8'h00;
  endfunction

  initial begin
    edge_count = 0;
    drive_en   = 1'b0;
  end

  // Sample on the rising sclk edge, change read data on the falling edge.
  always @(posedge sclk or negedge sclk or posedge cen) begin
    int          nib_index;
    logic [7:0]  cur_byte;
    if (cen) begin
      edge_count = 0;
      drive_en   = 1'b0;
    end else if (sclk) begin
      if (edge_count == 0) begin
        chip = cs;
      end
      nib_index = edge_count - 14;
      if (edge_count < 8) begin
        cmd = {cmd[6:0], lines[0]};
      end else if (edge_count < 14) begin
        dev_addr = {dev_addr[19:0], lines};
      end else if (cmd == op_quad_write) begin
        if (!nib_index[0]) begin
          high_nibble = lines;
        end else begin
          store[{chip, dev_addr + 24'(nib_index >> 1)}] = {high_nibble, lines};
        end
      end
      edge_count = edge_count + 1;
    end else begin
      // Six wait clocks follow the address before read data starts.
      nib_index = edge_count - 20;
      if (cmd == op_quad_read && edge_count >= 20 && edge_count < 28) begin
        cur_byte    = load_byte(chip, dev_addr + 24'(nib_index >> 1));
        drive_value = nib_index[0] ? cur_byte[3:0] : cur_byte[7:4];
        drive_en    = 1'b1;
      end else begin
        drive_en = 1'b0;
      end
    end
  end

endmodule

// ==== tests/tb_qspi_psram_ctrl.sv ====
// Testbench for the quad-SPI PSRAM controller.
// Random word traffic, byte and halfword merges and per-chip traffic are
// checked against a shadow memory, along with the valid/ready handshake and cen.

`timescale 1ns/10ps

module tb_qspi_psram_ctrl;

  typedef struct packed {
    logic        is_read;
    logic [31:0] data;
  } expect_t;

  localparam int rand_pairs   = 8;
  localparam int reset_cycles = 16;
  localparam int num_xfers    = 2 * rand_pairs + 9 + 5 + 8;
  localparam int cycle_limit  = num_xfers * 100 + reset_cycles;

  logic        clk;
  logic        resetn;
  logic [22:0] addr;
  logic [31:0] wdata;
  logic [3:0]  wstrb;
  logic        valid;
  logic [31:0] rdata;
  logic        ready;
  logic        cen;
  logic        sclk;
  logic [1:0]  cs;
  wire         sio0;
  wire         sio1;
  wire         sio2;
  wire         sio3;

  logic [31:0] lfsr_state = 32'h295;
  logic [31:0] shadow [logic [22:0]];
  expect_t     pending [$];
  int          cycle_count = 0;
  int          mismatches = 0;
  logic        ready_seen = 1'b0;

  qspi_psram_ctrl uut (
    .clk    (clk),
    .resetn (resetn),
    .addr   (addr),
    .wdata  (wdata),
    .wstrb  (wstrb),
    .valid  (valid),
    .rdata  (rdata),
    .ready  (ready),
    .cen    (cen),
    .sclk   (sclk),
    .cs     (cs),
    .sio0   (sio0),
    .sio1   (sio1),
    .sio2   (sio2),
    .sio3   (sio3)
  );

  psram_model chips (
    .cen  (cen),
    .sclk (sclk),
    .cs   (cs),
    .sio0 (sio0),
    .sio1 (sio1),
    .sio2 (sio2),
    .sio3 (sio3)
  );

  always #5 clk = ~clk;

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  // One LFSR step per bit taken.
  function automatic logic [31:0] random_bits(input int count);
    logic [31:0] value;
    value = 32'h0;
    for (int i = 0; i < count; i++) begin
      value      = {value[30:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
    return value;
  endfunction

  // Shadow word after the access; strobed lanes merge, a read leaves it alone.
  function automatic logic [31:0] reference_access(input logic [22:0] a,
                                                   input logic [31:0] d,
                                                   input logic [3:0]  s);
    logic [31:0] word;
    word = shadow.exists(a) ? shadow[a] : 32'h0;
    for (int lane = 0; lane < 4; lane++) begin
      if (s[lane]) begin
        word[lane*8 +: 8] = d[lane*8 +: 8];
      end
    end
    shadow[a] = word;
    return word;
  endfunction

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("** FAIL **");
    $fatal(1, "%s", reason);
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    if (got !== expected) begin
      mismatches++;
      $display("ERR %0t %s got %h expected %h", $time, name, got, expected);
      abort_run("value mismatch");
    end
  endtask

  // One request, with valid held a few cycles past ready.
  task automatic bus_access(input logic [22:0] a, input logic [31:0] d, input logic [3:0] s);
    expect_t item;
    item.is_read = (s == 4'b0000);
    item.data    = reference_access(a, d, s);
    pending.push_back(item);
    @(negedge clk);
    addr  = a;
    wdata = d;
    wstrb = s;
    valid = 1'b1;
    @(negedge clk);
    while (!ready) begin
      @(negedge clk);
    end
    check_value("cen", 32'(cen), 32'd1);
    repeat (3) begin
      @(negedge clk);
      check_value("ready", 32'(ready), 32'd1);
      check_value("cen", 32'(cen), 32'd1);
    end
    valid = 1'b0;
    wstrb = 4'b0000;
    @(negedge clk);
    check_value("ready", 32'(ready), 32'd0);
  endtask

  // Matches each rising ready with the oldest outstanding request.
  always @(negedge clk) begin
    expect_t item;
    logic    rise;
    rise       = resetn && ready && !ready_seen;
    ready_seen = ready;
    if (rise) begin
      if (pending.size() == 0) begin
        abort_run("ready rose with no request outstanding");
      end else begin
        item = pending.pop_front();
        if (item.is_read) begin
          check_value("rdata", rdata, item.data);
        end
      end
    end
  end

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > cycle_limit) begin
      abort_run($sformatf("test did not finish within %0d clock cycles", cycle_limit));
    end
  end

  initial begin
    logic [22:0] a;
    clk    = 1'b0;
    resetn = 1'b0;
    addr   = 23'h0;
    wdata  = 32'h0;
    wstrb  = 4'b0000;
    valid  = 1'b0;
    repeat (reset_cycles) begin
      @(negedge clk);
      check_value("ready", 32'(ready), 32'd0);
      check_value("cen", 32'(cen), 32'd1);
    end
    resetn = 1'b1;
    @(negedge clk);
    check_value("ready", 32'(ready), 32'd0);
    check_value("cen", 32'(cen), 32'd1);
    check_value("sclk", 32'(sclk), 32'd0);
    check_value("cs", 32'(cs), 32'd0);
    check_value("sio", 32'({sio3, sio2, sio1, sio0}), 32'd0);

    // Word write then read back at random addresses.
    for (int i = 0; i < rand_pairs; i++) begin
      a = 23'(random_bits(23));
      bus_access(a, random_bits(32), 4'b1111);
      bus_access(a, 32'h0, 4'b0000);
    end

    // One byte lane at a time, each followed by a word read.
    a = 23'(random_bits(23));
    bus_access(a, random_bits(32), 4'b1111);
    for (int lane = 0; lane < 4; lane++) begin
      bus_access(a, random_bits(32), 4'(1 << lane));
      bus_access(a, 32'h0, 4'b0000);
    end

    // Low and high halfword merges.
    a = 23'(random_bits(23));
    bus_access(a, random_bits(32), 4'b1111);
    bus_access(a, random_bits(32), 4'b0011);
    bus_access(a, 32'h0, 4'b0000);
    bus_access(a, random_bits(32), 4'b1100);
    bus_access(a, 32'h0, 4'b0000);

    // Same device address on every chip.
    a = 23'(random_bits(21));
    for (int c = 0; c < 4; c++) begin
      bus_access({2'(c), a[20:0]}, random_bits(32), 4'b1111);
    end
    for (int c = 0; c < 4; c++) begin
      bus_access({2'(c), a[20:0]}, 32'h0, 4'b0000);
    end

    if (pending.size() != 0) begin
      abort_run("a request never saw its ready");
    end
    if (mismatches == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule
